//--- ip_arp_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types for the Ethernet/ARP front end: addresses, frame structs,
// EtherType and ARP opcode enums, FSM states and ARP protocol constants
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ip_arp_pkg;

  typedef logic [47:0] mac_t;
  typedef logic [31:0] ip4_t;

  typedef enum logic [15:0] {
    ETH_TYPE_IPV4 = 16'h0800,
    ETH_TYPE_ARP  = 16'h0806
  } eth_type_e;

  typedef enum logic [15:0] {
    ARP_OPER_REQUEST = 16'd1,
    ARP_OPER_REPLY   = 16'd2
  } arp_oper_e;

  // Raw EtherType, so unknown types pass through
  typedef struct packed {
    mac_t        dest_mac;
    mac_t        src_mac;
    logic [15:0] eth_type;
  } eth_hdr_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
    logic       user;
  } eth_beat_t;

  typedef struct packed {
    mac_t sender_mac;
    ip4_t sender_ip;
  } arp_req_t;

  typedef enum logic [1:0] {
    ROUTE_NONE,
    ROUTE_IP,
    ROUTE_ARP,
    ROUTE_DROP
  } route_e;

  typedef enum logic [1:0] {
    RPL_IDLE,
    RPL_HDR,
    RPL_PAYLOAD
  } reply_state_e;

  localparam int ARP_LEN   = 28;
  localparam int ARP_IDX_W = 5;

  localparam logic [15:0] ARP_HTYPE_ETH = 16'd1;
  localparam logic [7:0]  ARP_HLEN      = 8'd6;
  localparam logic [7:0]  ARP_PLEN      = 8'd4;

endpackage

`default_nettype wire

//--- eth_dispatch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Receive dispatch: routes each frame by EtherType to IP, ARP or drop
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module eth_dispatch import ip_arp_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      s_hdr_valid,
  output logic      s_hdr_ready,
  input  eth_hdr_t  s_hdr,
  input  logic      s_pay_valid,
  output logic      s_pay_ready,
  input  eth_beat_t s_pay,
  output logic      ip_hdr_valid,
  input  logic      ip_hdr_ready,
  output eth_hdr_t  ip_hdr,
  output logic      ip_pay_valid,
  input  logic      ip_pay_ready,
  output eth_beat_t ip_pay,
  output logic      arp_pay_valid,
  input  logic      arp_pay_ready,
  output eth_beat_t arp_pay
);

  route_e hdr_route;
  route_e route_q;
  logic   hdr_idle;

  always_comb begin
    case (s_hdr.eth_type)
      ETH_TYPE_IPV4: hdr_route = ROUTE_IP;
      ETH_TYPE_ARP:  hdr_route = ROUTE_ARP;
      default:       hdr_route = ROUTE_DROP;
    endcase
  end

  // No new header until the current frame has seen its last beat
  assign hdr_idle = (route_q == ROUTE_NONE);

  assign ip_hdr_valid = s_hdr_valid && hdr_idle && (hdr_route == ROUTE_IP);
  assign ip_hdr       = s_hdr;
  assign s_hdr_ready  = s_hdr_valid && hdr_idle && ((hdr_route != ROUTE_IP) || ip_hdr_ready);

  assign ip_pay_valid  = s_pay_valid && (route_q == ROUTE_IP);
  assign ip_pay        = s_pay;
  assign arp_pay_valid = s_pay_valid && (route_q == ROUTE_ARP);
  assign arp_pay       = s_pay;

  always_comb begin
    case (route_q)
      ROUTE_IP:   s_pay_ready = ip_pay_ready;
      ROUTE_ARP:  s_pay_ready = arp_pay_ready;
      ROUTE_DROP: s_pay_ready = 1'b1;
      default:    s_pay_ready = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      route_q <= ROUTE_NONE;
    end else if (s_hdr_valid && s_hdr_ready) begin
      route_q <= hdr_route;
    end else if (s_pay_valid && s_pay_ready && s_pay.last) begin
      route_q <= ROUTE_NONE;
    end
  end

endmodule

`default_nettype wire

//--- arp_byte_counter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ARP payload byte index, saturating one past the final byte
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module arp_byte_counter import ip_arp_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 clear,
  input  logic                 step,
  output logic [ARP_IDX_W-1:0] idx,
  output logic                 at_end
);

  localparam logic [ARP_IDX_W-1:0] IDX_LAST = ARP_IDX_W'(ARP_LEN - 1);
  localparam logic [ARP_IDX_W-1:0] IDX_FULL = ARP_IDX_W'(ARP_LEN);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      idx <= '0;
    end else if (step && (idx != IDX_FULL)) begin
      idx <= idx + 1'b1;
    end
  end

  assign at_end = (idx == IDX_LAST);

endmodule

`default_nettype wire

//--- arp_rx_parser.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ARP receive parser: captures request fields, checks them and holds
// one reply record for the reply FSM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module arp_rx_parser import ip_arp_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      pay_valid,
  output logic      pay_ready,
  input  eth_beat_t pay,
  input  ip4_t      local_ip,
  output logic      rec_valid,
  input  logic      rec_ready,
  output arp_req_t  rec
);

  localparam logic [ARP_IDX_W-1:0] IDX_FULL = ARP_IDX_W'(ARP_LEN);

  logic [ARP_IDX_W-1:0] idx;
  logic                 at_end;
  logic                 beat_acc;
  logic                 req_ok;
  logic [15:0]          htype_q;
  logic [15:0]          ptype_q;
  logic [7:0]           hlen_q;
  logic [7:0]           plen_q;
  logic [15:0]          oper_q;
  mac_t                 sha_q;
  ip4_t                 spa_q;
  ip4_t                 tpa_q;
  ip4_t                 tpa_chk;

  // Parser stalls while a record waits for the FSM
  assign pay_ready = !rec_valid;
  assign beat_acc  = pay_valid && pay_ready;

  arp_byte_counter u_rx_cnt (
    .clk    (clk),
    .rst    (rst),
    .clear  (beat_acc && pay.last),
    .step   (beat_acc),
    .idx    (idx),
    .at_end (at_end)
  );

  // Fields are big endian, shifted in MSB first
  always_ff @(posedge clk) begin
    if (beat_acc) begin
      if (idx < 5'd2) htype_q <= {htype_q[7:0], pay.data};
      else if (idx < 5'd4) ptype_q <= {ptype_q[7:0], pay.data};
      else if (idx == 5'd4) hlen_q <= pay.data;
      else if (idx == 5'd5) plen_q <= pay.data;
      else if (idx < 5'd8) oper_q <= {oper_q[7:0], pay.data};
      else if (idx < 5'd14) sha_q <= {sha_q[39:0], pay.data};
      else if (idx < 5'd18) spa_q <= {spa_q[23:0], pay.data};
      else if ((idx >= 5'd24) && (idx < IDX_FULL)) tpa_q <= {tpa_q[23:0], pay.data};
    end
  end

  // final target IP byte lands in the same beat as the check
  assign tpa_chk = at_end ? {tpa_q[23:0], pay.data} : tpa_q;

  assign req_ok = (at_end || (idx == IDX_FULL)) && !pay.user &&
                  (htype_q == ARP_HTYPE_ETH) && (ptype_q == ETH_TYPE_IPV4) &&
                  (hlen_q == ARP_HLEN) && (plen_q == ARP_PLEN) &&
                  (oper_q == ARP_OPER_REQUEST) && (tpa_chk == local_ip);

  always_ff @(posedge clk) begin
    if (rst) begin
      rec_valid <= 1'b0;
    end else if (rec_valid && rec_ready) begin
      rec_valid <= 1'b0;
    end else if (beat_acc && pay.last && req_ok) begin
      rec_valid <= 1'b1;
    end
  end

  assign rec = '{sender_mac: sha_q, sender_ip: spa_q};

endmodule

`default_nettype wire

//--- arp_reply_builder.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ARP reply payload byte select by index
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module arp_reply_builder import ip_arp_pkg::*; (
  input  logic [ARP_IDX_W-1:0] idx,
  input  arp_req_t             req,
  input  mac_t                 local_mac,
  input  ip4_t                 local_ip,
  output logic [7:0]           data
);

  localparam logic [ARP_IDX_W-1:0] IDX_LAST = ARP_IDX_W'(ARP_LEN - 1);

  // Byte 0 of the reply sits in the top entry
  logic [ARP_LEN-1:0][7:0] reply_bytes;

  assign reply_bytes = {
    ARP_HTYPE_ETH,
    ETH_TYPE_IPV4,
    ARP_HLEN,
    ARP_PLEN,
    ARP_OPER_REPLY,
    local_mac,
    local_ip,
    req.sender_mac,
    req.sender_ip
  };

  always_comb begin
    if (idx <= IDX_LAST) begin
      data = reply_bytes[IDX_LAST - idx];
    end else begin
      data = 8'h00;
    end
  end

endmodule

`default_nettype wire

//--- arp_reply_fsm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ARP reply FSM: one reply frame, header then 28 bytes, per record
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module arp_reply_fsm import ip_arp_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      rec_valid,
  output logic      rec_ready,
  input  arp_req_t  rec,
  input  mac_t      local_mac,
  input  ip4_t      local_ip,
  output logic      hdr_valid,
  input  logic      hdr_ready,
  output eth_hdr_t  hdr,
  output logic      pay_valid,
  input  logic      pay_ready,
  output eth_beat_t pay
);

  reply_state_e         state_q;
  arp_req_t             req_q;
  logic [ARP_IDX_W-1:0] idx;
  logic                 at_end;
  logic [7:0]           reply_data;
  logic                 rec_acc;
  logic                 beat_acc;

  assign rec_ready = (state_q == RPL_IDLE);
  assign rec_acc   = rec_valid && rec_ready;
  assign hdr_valid = (state_q == RPL_HDR);
  assign pay_valid = (state_q == RPL_PAYLOAD);
  assign beat_acc  = pay_valid && pay_ready;

  arp_byte_counter u_tx_cnt (
    .clk    (clk),
    .rst    (rst),
    .clear  (rec_acc),
    .step   (beat_acc),
    .idx    (idx),
    .at_end (at_end)
  );

  arp_reply_builder u_builder (
    .idx       (idx),
    .req       (req_q),
    .local_mac (local_mac),
    .local_ip  (local_ip),
    .data      (reply_data)
  );

  always_ff @(posedge clk) begin
    if (rec_acc) begin
      req_q <= rec;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RPL_IDLE;
    end else begin
      case (state_q)
        RPL_IDLE:    if (rec_acc) state_q <= RPL_HDR;
        RPL_HDR:     if (hdr_ready) state_q <= RPL_PAYLOAD;
        RPL_PAYLOAD: if (beat_acc && at_end) state_q <= RPL_IDLE;
        default:     state_q <= RPL_IDLE;
      endcase
    end
  end

  // Reply goes back to the requester
  assign hdr = '{dest_mac: req_q.sender_mac, src_mac: local_mac, eth_type: ETH_TYPE_ARP};
  assign pay = '{data: reply_data, last: at_end, user: 1'b0};

endmodule

`default_nettype wire

//--- eth_tx_arb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-input Ethernet frame arbiter, input a has priority, whole frames
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module eth_tx_arb import ip_arp_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      a_hdr_valid,
  output logic      a_hdr_ready,
  input  eth_hdr_t  a_hdr,
  input  logic      a_pay_valid,
  output logic      a_pay_ready,
  input  eth_beat_t a_pay,
  input  logic      b_hdr_valid,
  output logic      b_hdr_ready,
  input  eth_hdr_t  b_hdr,
  input  logic      b_pay_valid,
  output logic      b_pay_ready,
  input  eth_beat_t b_pay,
  output logic      m_hdr_valid,
  input  logic      m_hdr_ready,
  output eth_hdr_t  m_hdr,
  output logic      m_pay_valid,
  input  logic      m_pay_ready,
  output eth_beat_t m_pay
);

  // sel high picks input b
  logic lock_q;
  logic hold_q;
  logic sel_q;
  logic sel;

  // Keep the choice once a header is offered so m_hdr stays stable
  assign sel = (lock_q || hold_q) ? sel_q : !a_hdr_valid;

  assign m_hdr_valid = !lock_q && (sel ? b_hdr_valid : a_hdr_valid);
  assign m_hdr       = sel ? b_hdr : a_hdr;
  assign a_hdr_ready = !lock_q && !sel && m_hdr_ready;
  assign b_hdr_ready = !lock_q && sel && m_hdr_ready;

  assign m_pay_valid = lock_q && (sel_q ? b_pay_valid : a_pay_valid);
  assign m_pay       = sel_q ? b_pay : a_pay;
  assign a_pay_ready = lock_q && !sel_q && m_pay_ready;
  assign b_pay_ready = lock_q && sel_q && m_pay_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      lock_q <= 1'b0;
      hold_q <= 1'b0;
      sel_q  <= 1'b0;
    end else begin
      if (m_hdr_valid) begin
        sel_q <= sel;
        if (m_hdr_ready) begin
          lock_q <= 1'b1;
          hold_q <= 1'b0;
        end else begin
          hold_q <= 1'b1;
        end
      end
      // Grant released after the last beat
      if (m_pay_valid && m_pay_ready && m_pay.last) begin
        lock_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- ip_arp_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ethernet front end top: dispatch, ARP reply path and transmit arbiter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ip_arp_top import ip_arp_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      s_eth_hdr_valid,
  output logic      s_eth_hdr_ready,
  input  eth_hdr_t  s_eth_hdr,
  input  logic      s_eth_pay_valid,
  output logic      s_eth_pay_ready,
  input  eth_beat_t s_eth_pay,
  output logic      m_ip_hdr_valid,
  input  logic      m_ip_hdr_ready,
  output eth_hdr_t  m_ip_hdr,
  output logic      m_ip_pay_valid,
  input  logic      m_ip_pay_ready,
  output eth_beat_t m_ip_pay,
  input  logic      s_tx_hdr_valid,
  output logic      s_tx_hdr_ready,
  input  eth_hdr_t  s_tx_hdr,
  input  logic      s_tx_pay_valid,
  output logic      s_tx_pay_ready,
  input  eth_beat_t s_tx_pay,
  output logic      m_eth_hdr_valid,
  input  logic      m_eth_hdr_ready,
  output eth_hdr_t  m_eth_hdr,
  output logic      m_eth_pay_valid,
  input  logic      m_eth_pay_ready,
  output eth_beat_t m_eth_pay,
  input  mac_t      local_mac,
  input  ip4_t      local_ip
);

  logic      arp_rx_valid;
  logic      arp_rx_ready;
  eth_beat_t arp_rx_pay;
  logic      rec_valid;
  logic      rec_ready;
  arp_req_t  rec;
  logic      arp_tx_hdr_valid;
  logic      arp_tx_hdr_ready;
  eth_hdr_t  arp_tx_hdr;
  logic      arp_tx_pay_valid;
  logic      arp_tx_pay_ready;
  eth_beat_t arp_tx_pay;

  eth_dispatch u_dispatch (
    .clk           (clk),
    .rst           (rst),
    .s_hdr_valid   (s_eth_hdr_valid),
    .s_hdr_ready   (s_eth_hdr_ready),
    .s_hdr         (s_eth_hdr),
    .s_pay_valid   (s_eth_pay_valid),
    .s_pay_ready   (s_eth_pay_ready),
    .s_pay         (s_eth_pay),
    .ip_hdr_valid  (m_ip_hdr_valid),
    .ip_hdr_ready  (m_ip_hdr_ready),
    .ip_hdr        (m_ip_hdr),
    .ip_pay_valid  (m_ip_pay_valid),
    .ip_pay_ready  (m_ip_pay_ready),
    .ip_pay        (m_ip_pay),
    .arp_pay_valid (arp_rx_valid),
    .arp_pay_ready (arp_rx_ready),
    .arp_pay       (arp_rx_pay)
  );

  arp_rx_parser u_parser (
    .clk       (clk),
    .rst       (rst),
    .pay_valid (arp_rx_valid),
    .pay_ready (arp_rx_ready),
    .pay       (arp_rx_pay),
    .local_ip  (local_ip),
    .rec_valid (rec_valid),
    .rec_ready (rec_ready),
    .rec       (rec)
  );

  arp_reply_fsm u_reply (
    .clk       (clk),
    .rst       (rst),
    .rec_valid (rec_valid),
    .rec_ready (rec_ready),
    .rec       (rec),
    .local_mac (local_mac),
    .local_ip  (local_ip),
    .hdr_valid (arp_tx_hdr_valid),
    .hdr_ready (arp_tx_hdr_ready),
    .hdr       (arp_tx_hdr),
    .pay_valid (arp_tx_pay_valid),
    .pay_ready (arp_tx_pay_ready),
    .pay       (arp_tx_pay)
  );

  // ARP replies on input a, external traffic on b
  eth_tx_arb u_arb (
    .clk         (clk),
    .rst         (rst),
    .a_hdr_valid (arp_tx_hdr_valid),
    .a_hdr_ready (arp_tx_hdr_ready),
    .a_hdr       (arp_tx_hdr),
    .a_pay_valid (arp_tx_pay_valid),
    .a_pay_ready (arp_tx_pay_ready),
    .a_pay       (arp_tx_pay),
    .b_hdr_valid (s_tx_hdr_valid),
    .b_hdr_ready (s_tx_hdr_ready),
    .b_hdr       (s_tx_hdr),
    .b_pay_valid (s_tx_pay_valid),
    .b_pay_ready (s_tx_pay_ready),
    .b_pay       (s_tx_pay),
    .m_hdr_valid (m_eth_hdr_valid),
    .m_hdr_ready (m_eth_hdr_ready),
    .m_hdr       (m_eth_hdr),
    .m_pay_valid (m_eth_pay_valid),
    .m_pay_ready (m_eth_pay_ready),
    .m_pay       (m_eth_pay)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock source, 40 ns period
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_NS = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_NS) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- tb_ip_arp.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the Ethernet/ARP front end: stimulus, LFSR, reference
// model, output checker and watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_ip_arp import ip_arp_pkg::*; ;

  // Bound on beats over all tests with 40 cycles of 40 ns per beat
  localparam longint TOTAL_BEATS = 2600;
  localparam longint WATCHDOG_NS = (TOTAL_BEATS * 40 + 1000) * 40;
  localparam mac_t   LOCAL_MAC   = 48'h0200_0000_0001;
  localparam ip4_t   LOCAL_IP    = 32'hC0A8_0164;

  logic      clk;
  logic      rst;
  logic      s_eth_hdr_valid, s_eth_hdr_ready, s_eth_pay_valid, s_eth_pay_ready;
  eth_hdr_t  s_eth_hdr;
  eth_beat_t s_eth_pay;
  logic      m_ip_hdr_valid, m_ip_hdr_ready, m_ip_pay_valid, m_ip_pay_ready;
  eth_hdr_t  m_ip_hdr;
  eth_beat_t m_ip_pay;
  logic      s_tx_hdr_valid, s_tx_hdr_ready, s_tx_pay_valid, s_tx_pay_ready;
  eth_hdr_t  s_tx_hdr;
  eth_beat_t s_tx_pay;
  logic      m_eth_hdr_valid, m_eth_hdr_ready, m_eth_pay_valid, m_eth_pay_ready;
  eth_hdr_t  m_eth_hdr;
  eth_beat_t m_eth_pay;

  logic [15:0] lfsr_state = 16'd14939;
  logic [7:0]  rx_bytes[$];
  logic [7:0]  tx_bytes[$];
  eth_hdr_t    exp_ip_hdr[$], exp_arp_hdr[$], exp_tx_hdr[$];
  eth_beat_t   exp_ip_pay[$], exp_arp_pay[$], exp_tx_pay[$];
  logic        eth_busy;
  logic        eth_from_tx;

  tb_clk_gen u_clk (.clk(clk));

  ip_arp_top DUT (.*, .local_mac(LOCAL_MAC), .local_ip(LOCAL_IP));

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  // Expected reply payload byte by index
  function automatic logic [7:0] arp_reply_byte(input int idx, input mac_t smac,
                                                input ip4_t sip);
    if (idx == 1) return 8'h01;
    if (idx == 2) return 8'h08;
    if (idx == 4) return 8'h06;
    if (idx == 5) return 8'h04;
    if (idx == 7) return 8'h02;
    if (idx >= 8 && idx < 14) return LOCAL_MAC[47 - 8 * (idx - 8) -: 8];
    if (idx >= 14 && idx < 18) return LOCAL_IP[31 - 8 * (idx - 14) -: 8];
    if (idx >= 18 && idx < 24) return smac[47 - 8 * (idx - 18) -: 8];
    if (idx >= 24 && idx < 28) return sip[31 - 8 * (idx - 24) -: 8];
    return 8'h00;
  endfunction

  // Whether the ARP frame in rx_bytes earns a reply
  function automatic bit reply_expected(input logic bad_last);
    if (rx_bytes.size() < ARP_LEN || bad_last) return 1'b0;
    if ({rx_bytes[0], rx_bytes[1]} != 16'd1 || {rx_bytes[2], rx_bytes[3]} != 16'h0800)
      return 1'b0;
    if (rx_bytes[4] != 8'd6 || rx_bytes[5] != 8'd4) return 1'b0;
    if ({rx_bytes[6], rx_bytes[7]} != 16'd1) return 1'b0;
    return {rx_bytes[24], rx_bytes[25], rx_bytes[26], rx_bytes[27]} == LOCAL_IP;
  endfunction

  // Queue the outputs one received frame should produce
  task automatic expect_rx(input eth_hdr_t h, input logic bad_last);
    mac_t      smac;
    ip4_t      sip;
    int        n;
    eth_beat_t b;
    eth_hdr_t  rh;
    n = rx_bytes.size();
    if (h.eth_type == 16'h0800) begin
      exp_ip_hdr.push_back(h);
      for (int i = 0; i < n; i++) begin
        b = '{data: rx_bytes[i], last: i == n - 1, user: bad_last && i == n - 1};
        exp_ip_pay.push_back(b);
      end
    end else if (h.eth_type == 16'h0806 && reply_expected(bad_last)) begin
      smac = {rx_bytes[8], rx_bytes[9], rx_bytes[10], rx_bytes[11], rx_bytes[12], rx_bytes[13]};
      sip  = {rx_bytes[14], rx_bytes[15], rx_bytes[16], rx_bytes[17]};
      rh   = '{dest_mac: smac, src_mac: LOCAL_MAC, eth_type: 16'h0806};
      exp_arp_hdr.push_back(rh);
      for (int i = 0; i < ARP_LEN; i++) begin
        b = '{data: arp_reply_byte(i, smac, sip), last: i == ARP_LEN - 1, user: 1'b0};
        exp_arp_pay.push_back(b);
      end
    end
  endtask

  task automatic make_arp(input logic [15:0] oper, input ip4_t tip, input int len);
    logic [31:0]  sip;
    logic [47:0]  smac;
    logic [223:0] frame;
    smac  = {16'h0200, rand_bits(32)};
    sip   = rand_bits(32);
    frame = {16'h0001, 16'h0800, 8'h06, 8'h04, oper, smac, sip, 48'h0, tip};
    rx_bytes.delete();
    for (int i = 0; i < len; i++) rx_bytes.push_back(frame[223 - 8 * i -: 8]);
  endtask

  task automatic make_random(input int len);
    rx_bytes.delete();
    for (int i = 0; i < len; i++) rx_bytes.push_back(8'(rand_bits(8)));
  endtask

  task automatic send_rx(input logic [15:0] etype, input logic bad_last);
    eth_hdr_t h;
    int       n;
    h = '{dest_mac: LOCAL_MAC, src_mac: {16'h0200, rand_bits(32)}, eth_type: etype};
    n = rx_bytes.size();
    expect_rx(h, bad_last);
    @(negedge clk);
    s_eth_hdr_valid = 1'b1;
    s_eth_hdr = h;
    do @(posedge clk); while (!s_eth_hdr_ready);
    @(negedge clk);
    s_eth_hdr_valid = 1'b0;
    for (int i = 0; i < n; i++) begin
      s_eth_pay_valid = 1'b1;
      s_eth_pay = '{data: rx_bytes[i], last: i == n - 1, user: bad_last && i == n - 1};
      do @(posedge clk); while (!s_eth_pay_ready);
      @(negedge clk);
    end
    s_eth_pay_valid = 1'b0;
  endtask

  task automatic send_tx(input int len);
    eth_hdr_t  h;
    eth_beat_t b;
    h = '{dest_mac: {16'h0400, rand_bits(32)}, src_mac: LOCAL_MAC, eth_type: 16'h0800};
    tx_bytes.delete();
    for (int i = 0; i < len; i++) tx_bytes.push_back(8'(rand_bits(8)));
    exp_tx_hdr.push_back(h);
    for (int i = 0; i < len; i++) begin
      b = '{data: tx_bytes[i], last: i == len - 1, user: 1'b0};
      exp_tx_pay.push_back(b);
    end
    @(negedge clk);
    s_tx_hdr_valid = 1'b1;
    s_tx_hdr = h;
    do @(posedge clk); while (!s_tx_hdr_ready);
    @(negedge clk);
    s_tx_hdr_valid = 1'b0;
    for (int i = 0; i < len; i++) begin
      s_tx_pay_valid = 1'b1;
      s_tx_pay = '{data: tx_bytes[i], last: i == len - 1, user: 1'b0};
      do @(posedge clk); while (!s_tx_pay_ready);
      @(negedge clk);
    end
    s_tx_pay_valid = 1'b0;
  endtask

  task automatic check_val(input string name, input logic [111:0] exp, input logic [111:0] got);
    assert (got === exp) else begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("Error at %0t: %s", $time, what);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // Output checker sampled on the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      if (m_ip_hdr_valid && m_ip_hdr_ready) begin
        check_true(exp_ip_hdr.size() > 0, "IP header appeared with no frame expected");
        check_val("m_ip_hdr", 112'(exp_ip_hdr.pop_front()), 112'(m_ip_hdr));
      end
      if (m_ip_pay_valid && m_ip_pay_ready) begin
        check_true(exp_ip_pay.size() > 0, "IP payload beat appeared with none expected");
        check_val("m_ip_pay", 112'(exp_ip_pay.pop_front()), 112'(m_ip_pay));
      end
      if (m_eth_hdr_valid && m_eth_hdr_ready) begin
        check_true(!eth_busy, "new m_eth header before the previous frame ended");
        eth_from_tx = (m_eth_hdr.eth_type != 16'h0806);
        eth_busy = 1'b1;
        if (eth_from_tx) begin
          check_true(exp_tx_hdr.size() > 0, "transmit frame appeared with none expected");
          check_val("m_eth_hdr", 112'(exp_tx_hdr.pop_front()), 112'(m_eth_hdr));
        end else begin
          check_true(exp_arp_hdr.size() > 0, "ARP reply appeared with none expected");
          check_val("m_eth_hdr", 112'(exp_arp_hdr.pop_front()), 112'(m_eth_hdr));
        end
      end
      if (m_eth_pay_valid && m_eth_pay_ready) begin
        check_true(eth_busy, "m_eth payload beat outside a frame");
        if (eth_from_tx) begin
          check_true(exp_tx_pay.size() > 0, "transmit payload beat appeared with none expected");
          check_val("m_eth_pay", 112'(exp_tx_pay.pop_front()), 112'(m_eth_pay));
        end else begin
          check_true(exp_arp_pay.size() > 0, "ARP reply beat appeared with none expected");
          check_val("m_eth_pay", 112'(exp_arp_pay.pop_front()), 112'(m_eth_pay));
        end
        if (m_eth_pay.last) eth_busy = 1'b0;
      end
    end
  end

  // Random back-pressure that is mostly ready
  always @(negedge clk) begin
    m_ip_hdr_ready  = rand_bits(2) != 0;
    m_ip_pay_ready  = rand_bits(2) != 0;
    m_eth_hdr_ready = rand_bits(2) != 0;
    m_eth_pay_ready = rand_bits(2) != 0;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish in time");
    $display("TB FAILED");
    $fatal(1);
  end

  initial begin
    int wait_cycles;
    rst = 1'b1;
    s_eth_hdr_valid = 1'b0;
    s_eth_hdr = '0;
    s_eth_pay_valid = 1'b0;
    s_eth_pay = '0;
    s_tx_hdr_valid = 1'b0;
    s_tx_hdr = '0;
    s_tx_pay_valid = 1'b0;
    s_tx_pay = '0;
    m_ip_hdr_ready = 1'b0;
    m_ip_pay_ready = 1'b0;
    m_eth_hdr_ready = 1'b0;
    m_eth_pay_ready = 1'b0;
    eth_busy = 1'b0;
    eth_from_tx = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Valid request then the frames that must not answer
    make_arp(16'd1, LOCAL_IP, ARP_LEN);
    send_rx(16'h0806, 1'b0);
    make_arp(16'd1, LOCAL_IP ^ 32'h1, ARP_LEN);
    send_rx(16'h0806, 1'b0);
    make_arp(16'd2, LOCAL_IP, ARP_LEN);
    send_rx(16'h0806, 1'b0);
    make_arp(16'd1, LOCAL_IP, 20);
    send_rx(16'h0806, 1'b0);
    make_arp(16'd1, LOCAL_IP, ARP_LEN);
    send_rx(16'h0806, 1'b1);
    make_arp(16'd1, LOCAL_IP, ARP_LEN);
    send_rx(16'h0806, 1'b0);

    // IPv4 and unknown types
    for (int i = 0; i < 4; i++) begin
      make_random(1 + int'(rand_bits(5)));
      send_rx(16'h0800, 1'b0);
      make_random(1 + int'(rand_bits(4)));
      send_rx(16'h86DD, 1'b0);
    end

    // Contention with external traffic and a random mix
    fork
      for (int i = 0; i < 24; i++) begin
        case (rand_bits(2))
          0: make_arp(16'd1, LOCAL_IP, ARP_LEN);
          1: make_random(1 + int'(rand_bits(5)));
          2: make_random(1 + int'(rand_bits(4)));
          default: make_arp(16'd1, LOCAL_IP, ARP_LEN);
        endcase
        if (rx_bytes.size() == ARP_LEN && rx_bytes[0] == 8'h00 && rx_bytes[1] == 8'h01)
          send_rx(16'h0806, 1'b0);
        else if (rx_bytes.size() > 16)
          send_rx(16'h0800, 1'b0);
        else
          send_rx(16'h88B5, 1'b0);
      end
      for (int i = 0; i < 16; i++) send_tx(1 + int'(rand_bits(5)));
    join

    wait_cycles = 0;
    while ((exp_ip_hdr.size() + exp_arp_hdr.size() + exp_tx_hdr.size() +
            exp_ip_pay.size() + exp_arp_pay.size() + exp_tx_pay.size()) != 0 &&
           wait_cycles < 2000) begin
      @(posedge clk);
      wait_cycles++;
    end
    if ((exp_ip_hdr.size() + exp_arp_hdr.size() + exp_tx_hdr.size() +
         exp_ip_pay.size() + exp_arp_pay.size() + exp_tx_pay.size()) != 0) begin
      $display("Error: expected frames never appeared (ip %0d, arp %0d, tx %0d)",
               exp_ip_hdr.size(), exp_arp_hdr.size(), exp_tx_hdr.size());
      $display("TB FAILED");
      $fatal(1);
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
ip_arp_pkg.sv
eth_dispatch.sv
arp_byte_counter.sv
arp_rx_parser.sv
arp_reply_builder.sv
arp_reply_fsm.sv
eth_tx_arb.sv
ip_arp_top.sv
tb_clk_gen.sv
tb_ip_arp.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status reports pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ip_arp -f verilog.f -o sim_tb_ip_arp \
  && ./obj_dir/sim_tb_ip_arp \
  || exit 1
